// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MSX host glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_msx_glue -f vlog.f -o tb_msx_glue_sim \
   && ./obj_dir/tb_msx_glue_sim > sim.log 2>&1 \
   || echo "Build or simulation stopped with an error"

[ -f sim.log ] && cat sim.log

grep -qx "Result: PASSED" sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== source/glue_control.sv ====
//====================
// Glue control
// Builds the hard and core resets, arms the
// cassette after a CAS download and drives
// the OSD menu mask
//====================
`timescale 1ns/1ps

module glue_control (
   input  logic                                    clock_bus,
   input  logic                                    rst,
   input  glue_host_pkg::status_t                  status,
   input  logic                                    upload_reset,
   input  logic                                    sd_img_mounted,
   input  logic                                    fdc_enable,
   input  logic                                    ioctl_download,
   input  logic [glue_host_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
   input  logic                                    motor,
   input  logic                                    rom_a_hide,
   input  logic                                    rom_b_hide,
   input  logic                                    ocm_mode,
   input  logic [glue_host_pkg::FDD_SLOTS-1:0]     fdd_present,
   input  logic                                    sram_present,
   output logic                                    hard_reset,
   output logic                                    core_reset,
   output logic                                    play,
   output logic                                    rewind,
   output logic [glue_host_pkg::MENU_W-1:0]        menu_mask
);

   logic                             hard_terms;
   logic                             core_terms;
   logic                             is_cas;
   logic                             is_cas_d;
   logic                             cas_load;
   logic [glue_host_pkg::MENU_W-1:0] mask_next;

   //====================
   // Reset terms
   //====================
   assign hard_terms = rst || status[glue_host_pkg::ST_RESET] || upload_reset;

   // Mount reset only matters with the floppy controller present
   assign core_terms = hard_terms
                    || status[glue_host_pkg::ST_DETACH]
                    || status[glue_host_pkg::ST_OSD_RESET]
                    || (status[glue_host_pkg::ST_MOUNT_RESET] && sd_img_mounted && fdc_enable);

   always_ff @(posedge clock_bus) begin
      hard_reset <= hard_terms;
      core_reset <= core_terms;
   end

   //====================
   // Cassette
   //====================
   assign is_cas = ioctl_download
                && (ioctl_index[glue_host_pkg::IDX_MASK_W-1:0] == glue_host_pkg::IDX_CAS);

   // Arm on the trailing edge of a CAS download
   always_ff @(posedge clock_bus) begin
      if (rst || hard_reset) begin
         is_cas_d <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         is_cas_d <= is_cas;
         if (is_cas_d && !is_cas) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Tape runs while the motor relay is released
   assign play = !motor && cas_load;

   always_ff @(posedge clock_bus) begin
      rewind <= status[glue_host_pkg::ST_TAPE_REWIND] || is_cas || core_terms;
   end

   //====================
   // OSD menu mask
   //====================
   always_comb begin
      mask_next     = '0;
      mask_next[1]  = rom_a_hide || ocm_mode;
      mask_next[2]  = rom_b_hide || ocm_mode;
      mask_next[3]  = ocm_mode;
      mask_next[9:4] = fdd_present;
      mask_next[10] = !sram_present;
      mask_next[11] = status[glue_host_pkg::ST_TAPE_ADC];
   end

   always_ff @(posedge clock_bus) begin
      menu_mask <= mask_next;
   end

endmodule

// ==== source/glue_host_pkg.sv ====
//====================
// Host glue definitions
// Status word bit map, download index codes,
// OSD menu mask layout and SDRAM channel widths
//====================

package glue_host_pkg;

   //====================
   // OSD status word
   //====================
   localparam int STATUS_W = 64;

   typedef logic [STATUS_W-1:0] status_t;

   localparam int ST_RESET       = 0;
   // Aspect field is 2 bits wide, scale field 3 bits
   localparam int ST_ASPECT_LO   = 1;
   localparam int ST_SCALE_LO    = 3;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_DETACH      = 10;
   localparam int ST_MOUNT_RESET = 12;
   localparam int ST_OSD_RESET   = 21;
   localparam int ST_TAPE_ADC    = 40;

   //====================
   // Downloads and menu
   //====================
   localparam int IOCTL_INDEX_W = 16;
   localparam int IDX_MASK_W    = 6;

   // CAS file slot in the OSD file menu
   localparam logic [IDX_MASK_W-1:0] IDX_CAS = 6'd5;

   localparam int MENU_W    = 16;
   localparam int FDD_SLOTS = 6;

   //====================
   // SDRAM channel
   //====================
   localparam int MEM_ADDR_W = 27;
   localparam int MEM_DATA_W = 8;

   localparam logic [MEM_DATA_W-1:0] MEM_IDLE_DATA = {MEM_DATA_W{1'b1}};

endpackage

// ==== source/glue_video_pkg.sv ====
//====================
// Video option definitions
// Field widths, aspect defaults and the
// 1080p crop setting for the HDMI scaler
//====================

package glue_video_pkg;

   localparam int ASPECT_W = 2;
   localparam int SCALE_W  = 3;

   // Aspect ratio and crop words toward the scaler
   localparam int AR_W = 12;

   // Original 4:3 picture
   localparam logic [AR_W-1:0] AR_DEFAULT_X = 12'd4;
   localparam logic [AR_W-1:0] AR_DEFAULT_Y = 12'd3;

   localparam int HDMI_SIZE_W = 12;

   localparam logic [HDMI_SIZE_W-1:0] HDMI_1080_W = 12'd1920;
   localparam logic [HDMI_SIZE_W-1:0] HDMI_1080_H = 12'd1080;

   // 216 lines gives integer scaling at 1080p
   localparam logic [AR_W-1:0] CROP_1080 = 12'd216;

endpackage

// ==== source/msx_glue_top.sv ====
//====================
// MSX host glue top
// Connects reset and cassette control, SD card
// routing, SDRAM sharing and video option decode
//====================
`timescale 1ns/1ps

module msx_glue_top #(
   parameter int ACT_TIMEOUT = 1000000
) (
   input  logic                                    clock_bus,
   input  logic                                    rst,
   input  glue_host_pkg::status_t                  status,
   // Upload engine and OSD
   input  logic                                    upload_reset,
   input  logic                                    sd_img_mounted,
   input  logic                                    fdc_enable,
   input  logic                                    ioctl_download,
   input  logic [glue_host_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
   input  logic                                    motor,
   input  logic                                    rom_a_hide,
   input  logic                                    rom_b_hide,
   input  logic                                    ocm_mode,
   input  logic [glue_host_pkg::FDD_SLOTS-1:0]     fdd_present,
   input  logic                                    sram_present,
   output logic                                    hard_reset,
   output logic                                    core_reset,
   output logic                                    play,
   output logic                                    rewind,
   output logic [glue_host_pkg::MENU_W-1:0]        menu_mask,
   // SD card
   input  logic [63:0]                             img_size,
   input  logic                                    spi_sck,
   input  logic                                    spi_mosi,
   input  logic                                    sd_miso,
   input  logic                                    vsd_miso,
   output logic                                    sd_cs,
   output logic                                    sd_sck,
   output logic                                    sd_mosi,
   output logic                                    miso_to_core,
   output logic                                    led_user,
   output logic [1:0]                              led_disk,
   // SDRAM channel
   input  logic                                    upload,
   input  logic [glue_host_pkg::MEM_ADDR_W-1:0]    up_addr,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0]    up_data,
   input  logic                                    up_rnw,
   input  logic                                    up_cs,
   input  logic [glue_host_pkg::MEM_ADDR_W-1:0]    mx_addr,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0]    mx_data,
   input  logic                                    mx_rnw,
   input  logic                                    mx_cs,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0]    sdram_dout,
   input  logic                                    sdram_ready,
   output logic [glue_host_pkg::MEM_DATA_W-1:0]    up_q,
   output logic [glue_host_pkg::MEM_DATA_W-1:0]    mx_q,
   output logic                                    up_ready,
   output logic                                    mx_ready,
   output logic [glue_host_pkg::MEM_ADDR_W-1:0]    ch_addr,
   output logic [glue_host_pkg::MEM_DATA_W-1:0]    ch_din,
   output logic                                    ch_rnw,
   output logic                                    ch_req,
   // Video
   input  logic                                    forced_scandoubler,
   input  logic [glue_video_pkg::HDMI_SIZE_W-1:0]  hdmi_width,
   input  logic [glue_video_pkg::HDMI_SIZE_W-1:0]  hdmi_height,
   output logic [1:0]                              vga_sl,
   output logic                                    hq2x,
   output logic                                    scandoubler,
   output logic [glue_video_pkg::AR_W-1:0]         arx,
   output logic [glue_video_pkg::AR_W-1:0]         ary,
   output logic [glue_video_pkg::AR_W-1:0]         crop_size
);

   glue_control u_control (
      .clock_bus(clock_bus), .rst(rst), .status(status),
      .upload_reset(upload_reset), .sd_img_mounted(sd_img_mounted),
      .fdc_enable(fdc_enable), .ioctl_download(ioctl_download),
      .ioctl_index(ioctl_index), .motor(motor),
      .rom_a_hide(rom_a_hide), .rom_b_hide(rom_b_hide), .ocm_mode(ocm_mode),
      .fdd_present(fdd_present), .sram_present(sram_present),
      .hard_reset(hard_reset), .core_reset(core_reset),
      .play(play), .rewind(rewind), .menu_mask(menu_mask)
   );

   // Card routing returns to the physical card on hard reset
   sd_route #(
      .ACT_TIMEOUT(ACT_TIMEOUT)
   ) u_sd_route (
      .clock_bus(clock_bus), .hard_reset(hard_reset),
      .sd_img_mounted(sd_img_mounted), .img_size(img_size),
      .spi_sck(spi_sck), .spi_mosi(spi_mosi),
      .sd_miso(sd_miso), .vsd_miso(vsd_miso),
      .sd_cs(sd_cs), .sd_sck(sd_sck), .sd_mosi(sd_mosi),
      .miso_to_core(miso_to_core), .led_user(led_user), .led_disk(led_disk)
   );

   sdram_port_mux u_sdram_mux (
      .upload(upload),
      .up_addr(up_addr), .up_data(up_data), .up_rnw(up_rnw), .up_cs(up_cs),
      .mx_addr(mx_addr), .mx_data(mx_data), .mx_rnw(mx_rnw), .mx_cs(mx_cs),
      .sdram_dout(sdram_dout), .sdram_ready(sdram_ready),
      .up_q(up_q), .mx_q(mx_q), .up_ready(up_ready), .mx_ready(mx_ready),
      .ch_addr(ch_addr), .ch_din(ch_din), .ch_rnw(ch_rnw), .ch_req(ch_req)
   );

   video_option_decode u_video (
      .clock_bus(clock_bus), .rst(rst), .status(status),
      .forced_scandoubler(forced_scandoubler),
      .hdmi_width(hdmi_width), .hdmi_height(hdmi_height),
      .vga_sl(vga_sl), .hq2x(hq2x), .scandoubler(scandoubler),
      .arx(arx), .ary(ary), .crop_size(crop_size)
   );

endmodule

// ==== source/sd_route.sv ====
//====================
// SD card routing
// Picks the mounted card image or the physical
// SD pins and lights the disk LEDs on traffic
//====================
`timescale 1ns/1ps

module sd_route #(
   parameter int ACT_TIMEOUT = 1000000
) (
   input  logic        clock_bus,
   input  logic        hard_reset,
   input  logic        sd_img_mounted,
   input  logic [63:0] img_size,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        miso_to_core,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             spi_edge;
   logic             sd_act;
   logic [CNT_W-1:0] act_cnt;

   //====================
   // Card select
   //====================
   // An empty image falls back to the physical card
   always_ff @(posedge clock_bus) begin
      if (hard_reset) begin
         vsd_sel <= 1'b0;
      end else if (sd_img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   assign sd_cs        = vsd_sel;
   assign sd_sck       = spi_sck && !vsd_sel;
   assign sd_mosi      = spi_mosi && !vsd_sel;
   assign miso_to_core = vsd_sel ? vsd_miso : sd_miso;

   //====================
   // Activity timer
   //====================
   always_ff @(posedge clock_bus) begin
      old_mosi <= spi_mosi;
      old_miso <= miso_to_core;
   end

   assign spi_edge = (old_mosi ^ spi_mosi) || (old_miso ^ miso_to_core);

   // Saturates at ACT_TIMEOUT, which means idle
   always_ff @(posedge clock_bus) begin
      if (hard_reset) begin
         act_cnt <= CNT_W'(ACT_TIMEOUT);
      end else if (spi_edge) begin
         act_cnt <= '0;
      end else if (act_cnt < CNT_W'(ACT_TIMEOUT)) begin
         act_cnt <= act_cnt + 1'b1;
      end
   end

   assign sd_act = act_cnt < CNT_W'(ACT_TIMEOUT);

   // Upper disk LED bit hands control to this core
   assign led_user = vsd_sel && sd_act;
   assign led_disk = {1'b1, !vsd_sel && sd_act};

endmodule

// ==== source/sdram_port_mux.sv ====
//====================
// SDRAM port sharing
// The upload engine owns the channel while
// upload is high, the machine otherwise
//====================
`timescale 1ns/1ps

module sdram_port_mux (
   input  logic                                 upload,
   input  logic [glue_host_pkg::MEM_ADDR_W-1:0] up_addr,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0] up_data,
   input  logic                                 up_rnw,
   input  logic                                 up_cs,
   input  logic [glue_host_pkg::MEM_ADDR_W-1:0] mx_addr,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0] mx_data,
   input  logic                                 mx_rnw,
   input  logic                                 mx_cs,
   input  logic [glue_host_pkg::MEM_DATA_W-1:0] sdram_dout,
   input  logic                                 sdram_ready,
   output logic [glue_host_pkg::MEM_DATA_W-1:0] up_q,
   output logic [glue_host_pkg::MEM_DATA_W-1:0] mx_q,
   output logic                                 up_ready,
   output logic                                 mx_ready,
   output logic [glue_host_pkg::MEM_ADDR_W-1:0] ch_addr,
   output logic [glue_host_pkg::MEM_DATA_W-1:0] ch_din,
   output logic                                 ch_rnw,
   output logic                                 ch_req
);

   // Request side toward the controller
   assign ch_addr = upload ? up_addr : mx_addr;
   assign ch_din  = upload ? up_data : mx_data;
   assign ch_rnw  = upload ? up_rnw  : mx_rnw;
   assign ch_req  = upload ? up_cs   : mx_cs;

   // Unselected side reads an open bus
   assign up_q = up_cs ? sdram_dout : glue_host_pkg::MEM_IDLE_DATA;
   assign mx_q = mx_cs ? sdram_dout : glue_host_pkg::MEM_IDLE_DATA;

   assign up_ready = sdram_ready;
   assign mx_ready = sdram_ready;

endmodule

// ==== source/video_option_decode.sv ====
//====================
// Video option decode
// Scale, scanlines, aspect ratio and 1080p
// crop for the video mixer and scaler
//====================
`timescale 1ns/1ps

module video_option_decode (
   input  logic                                   clock_bus,
   input  logic                                   rst,
   input  glue_host_pkg::status_t                 status,
   input  logic                                   forced_scandoubler,
   input  logic [glue_video_pkg::HDMI_SIZE_W-1:0] hdmi_width,
   input  logic [glue_video_pkg::HDMI_SIZE_W-1:0] hdmi_height,
   output logic [1:0]                             vga_sl,
   output logic                                   hq2x,
   output logic                                   scandoubler,
   output logic [glue_video_pkg::AR_W-1:0]        arx,
   output logic [glue_video_pkg::AR_W-1:0]        ary,
   output logic [glue_video_pkg::AR_W-1:0]        crop_size
);

   logic [glue_video_pkg::SCALE_W-1:0]  scale;
   logic [glue_video_pkg::SCALE_W-1:0]  sl_level;
   logic [glue_video_pkg::ASPECT_W-1:0] aspect;
   logic [glue_video_pkg::ASPECT_W-1:0] aspect_m1;
   logic                                sd_next;
   logic                                is_1080p;

   assign scale  = status[glue_host_pkg::ST_SCALE_LO +: glue_video_pkg::SCALE_W];
   assign aspect = status[glue_host_pkg::ST_ASPECT_LO +: glue_video_pkg::ASPECT_W];

   // Level 0 is the plain picture, scanlines start at 2
   assign sl_level  = (scale != '0) ? scale - 1'b1 : '0;
   assign aspect_m1 = aspect - 1'b1;
   assign sd_next   = forced_scandoubler || (scale != '0);

   assign is_1080p = (hdmi_width == glue_video_pkg::HDMI_1080_W)
                  && (hdmi_height == glue_video_pkg::HDMI_1080_H);

   //====================
   // Output registers
   //====================
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         vga_sl      <= '0;
         hq2x        <= 1'b0;
         scandoubler <= 1'b0;
         arx         <= glue_video_pkg::AR_DEFAULT_X;
         ary         <= glue_video_pkg::AR_DEFAULT_Y;
         crop_size   <= '0;
      end else begin
         vga_sl      <= sl_level[1:0];
         hq2x        <= (scale == glue_video_pkg::SCALE_W'(1));
         scandoubler <= sd_next;
         if (aspect == '0) begin
            arx <= glue_video_pkg::AR_DEFAULT_X;
            ary <= glue_video_pkg::AR_DEFAULT_Y;
         end else begin
            // Custom aspect slots are passed as an index
            arx <= glue_video_pkg::AR_W'(aspect_m1);
            ary <= '0;
         end
         crop_size <= (is_1080p && !sd_next) ? glue_video_pkg::CROP_1080 : '0;
      end
   end

endmodule

// ==== tb/tb_clock_gen.sv ====
//====================
// Testbench clock and reset
// 4 ns clock, reset held high for the
// first cycles of the run
//====================
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 2,
   parameter int RESET_CYCLES = 8
) (
   output logic clock_bus,
   output logic rst
);

   initial begin
      clock_bus = 1'b0;
      forever begin
         #HALF_PERIOD clock_bus = ~clock_bus;
      end
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock_bus);
      @(negedge clock_bus);
      rst = 1'b0;
   end

endmodule

// ==== tb/tb_msx_glue.sv ====
//====================
// MSX host glue testbench
// Random stimulus from an xorshift source,
// a cycle model of the glue rules and
// per-cycle checks of every DUT output
//====================
`timescale 1ns/1ps

module tb_msx_glue;

   localparam int ACT_TIMEOUT    = 40;
   localparam int NUM_CYCLES     = 3000;
   localparam int CHECK_START    = 3;
   localparam int TIMEOUT_CYCLES = NUM_CYCLES + 1000;

   logic clock_bus, rst;
   glue_host_pkg::status_t status;
   logic upload_reset, sd_img_mounted, fdc_enable, ioctl_download, motor;
   logic [15:0] ioctl_index;
   logic rom_a_hide, rom_b_hide, ocm_mode, sram_present;
   logic [5:0] fdd_present;
   logic hard_reset, core_reset, play, rewind;
   logic [15:0] menu_mask;
   logic [63:0] img_size;
   logic spi_sck, spi_mosi, sd_miso, vsd_miso;
   logic sd_cs, sd_sck, sd_mosi, miso_to_core, led_user;
   logic [1:0] led_disk;
   logic upload, up_rnw, up_cs, mx_rnw, mx_cs, sdram_ready;
   logic [26:0] up_addr, mx_addr, ch_addr;
   logic [7:0] up_data, mx_data, sdram_dout, up_q, mx_q, ch_din;
   logic up_ready, mx_ready, ch_rnw, ch_req;
   logic forced_scandoubler, hq2x, scandoubler;
   logic [11:0] hdmi_width, hdmi_height, arx, ary, crop_size;
   logic [1:0] vga_sl;

   // Stimulus state
   logic [31:0] rng;
   logic [63:0] opt_bits;
   int cas_left;
   int burst_left;
   int cycle_count = 0;

   // Model state after the latest rising edge
   logic m_hard, m_core, m_rewind, m_is_cas_d, m_cas_load;
   logic m_vsd_sel, m_old_mosi, m_old_miso;
   int m_act_cnt;
   logic [15:0] m_menu;
   logic [1:0] m_vga_sl;
   logic m_hq2x, m_sd;
   logic [11:0] m_arx, m_ary, m_crop;

   tb_clock_gen u_clk (.clock_bus(clock_bus), .rst(rst));

   msx_glue_top #(.ACT_TIMEOUT(ACT_TIMEOUT)) u_dut (
      .clock_bus(clock_bus), .rst(rst), .status(status),
      .upload_reset(upload_reset), .sd_img_mounted(sd_img_mounted),
      .fdc_enable(fdc_enable), .ioctl_download(ioctl_download),
      .ioctl_index(ioctl_index), .motor(motor), .rom_a_hide(rom_a_hide),
      .rom_b_hide(rom_b_hide), .ocm_mode(ocm_mode), .fdd_present(fdd_present),
      .sram_present(sram_present), .hard_reset(hard_reset), .core_reset(core_reset),
      .play(play), .rewind(rewind), .menu_mask(menu_mask),
      .img_size(img_size), .spi_sck(spi_sck), .spi_mosi(spi_mosi),
      .sd_miso(sd_miso), .vsd_miso(vsd_miso), .sd_cs(sd_cs), .sd_sck(sd_sck),
      .sd_mosi(sd_mosi), .miso_to_core(miso_to_core), .led_user(led_user),
      .led_disk(led_disk), .upload(upload), .up_addr(up_addr), .up_data(up_data),
      .up_rnw(up_rnw), .up_cs(up_cs), .mx_addr(mx_addr), .mx_data(mx_data),
      .mx_rnw(mx_rnw), .mx_cs(mx_cs), .sdram_dout(sdram_dout),
      .sdram_ready(sdram_ready), .up_q(up_q), .mx_q(mx_q), .up_ready(up_ready),
      .mx_ready(mx_ready), .ch_addr(ch_addr), .ch_din(ch_din), .ch_rnw(ch_rnw),
      .ch_req(ch_req), .forced_scandoubler(forced_scandoubler),
      .hdmi_width(hdmi_width), .hdmi_height(hdmi_height), .vga_sl(vga_sl),
      .hq2x(hq2x), .scandoubler(scandoubler), .arx(arx), .ary(ary),
      .crop_size(crop_size)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   //====================
   // Stimulus
   //====================
   task automatic drive_inputs();
      logic [31:0] r;
      r = next_random();
      if (r[3:0] == 4'd0) begin
         opt_bits[31:0]  = next_random();
         opt_bits[63:32] = next_random();
         // Scale 0 half the time to reach the crop path
         if (r[4]) opt_bits[5:3] = 3'd0;
      end
      status = opt_bits;
      r = next_random();
      status[glue_host_pkg::ST_RESET]       = (r[5:0] == 6'd0);
      status[glue_host_pkg::ST_DETACH]      = (r[11:6] == 6'd0);
      status[glue_host_pkg::ST_OSD_RESET]   = (r[17:12] == 6'd0);
      status[glue_host_pkg::ST_MOUNT_RESET] = r[18];
      status[glue_host_pkg::ST_TAPE_REWIND] = (r[22:19] == 4'd0);
      upload_reset   = (r[28:23] == 6'd0);
      fdc_enable     = r[29];
      sd_img_mounted = (r[31:30] == 2'd0);
      r = next_random();
      if (r[1:0] == 2'd0) begin
         img_size = 64'd0;
      end else begin
         img_size = {next_random(), next_random()};
      end
      // CAS downloads come as windows of several cycles
      r = next_random();
      if (cas_left == 0 && r[5:0] == 6'd0) begin
         cas_left = 2 + int'(r[9:6]);
         if (r[12:11] != 2'd0) ioctl_index = {r[31:22], glue_host_pkg::IDX_CAS};
         else ioctl_index = r[31:16];
      end
      ioctl_download = (cas_left > 0);
      if (cas_left > 0) cas_left = cas_left - 1;
      if (r[15:13] == 3'd0) motor = r[16];
      rom_a_hide   = r[17];
      rom_b_hide   = r[18];
      ocm_mode     = r[19];
      sram_present = r[20];
      fdd_present  = r[26:21];
      // SPI traffic in bursts with long idle gaps
      r = next_random();
      if (burst_left == 0 && r[6:0] == 7'd0) burst_left = 4 + int'(r[10:7]);
      if (burst_left > 0) begin
         spi_sck    = r[11];
         spi_mosi   = r[12];
         sd_miso    = r[13];
         vsd_miso   = r[14];
         burst_left = burst_left - 1;
      end
      r = next_random();
      upload      = r[0];
      up_rnw      = r[1];
      up_cs       = r[2];
      mx_rnw      = r[3];
      mx_cs       = r[4];
      sdram_ready = r[5];
      up_data     = r[15:8];
      mx_data     = r[23:16];
      sdram_dout  = r[31:24];
      r = next_random();
      up_addr = r[26:0];
      r = next_random();
      mx_addr = r[26:0];
      r = next_random();
      if (r[2:0] == 3'd0) forced_scandoubler = (r[6:3] == 4'd0);
      if (r[10:7] == 4'd0) begin
         if (!r[11]) begin
            hdmi_width  = 12'd1920;
            hdmi_height = 12'd1080;
         end else if (r[12]) begin
            hdmi_width  = 12'd1920;
            hdmi_height = 12'd1200;
         end else begin
            hdmi_width  = r[27:16];
            hdmi_height = 12'd1080;
         end
      end
   endtask

   //====================
   // Reference model
   //====================
   task automatic step_model();
      logic       hard_terms;
      logic       core_terms;
      logic       cas_now;
      logic       miso_now;
      logic       edge_seen;
      logic [2:0] scale;
      logic [2:0] sl_full;
      logic [1:0] aspect;
      logic       sd_next;
      hard_terms = rst || status[glue_host_pkg::ST_RESET] || upload_reset;
      core_terms = hard_terms || status[glue_host_pkg::ST_DETACH]
                || status[glue_host_pkg::ST_OSD_RESET]
                || (status[glue_host_pkg::ST_MOUNT_RESET] && sd_img_mounted && fdc_enable);
      cas_now   = ioctl_download && (ioctl_index[5:0] == 6'd5);
      miso_now  = m_vsd_sel ? vsd_miso : sd_miso;
      edge_seen = (spi_mosi != m_old_mosi) || (miso_now != m_old_miso);
      // Cassette arming sees the hard reset of the previous edge
      if (rst || m_hard) begin
         m_is_cas_d = 1'b0;
         m_cas_load = 1'b0;
      end else begin
         if (m_is_cas_d && !cas_now) m_cas_load = 1'b1;
         m_is_cas_d = cas_now;
      end
      m_rewind = status[glue_host_pkg::ST_TAPE_REWIND] || cas_now || core_terms;
      if (m_hard) m_act_cnt = ACT_TIMEOUT;
      else if (edge_seen) m_act_cnt = 0;
      else if (m_act_cnt < ACT_TIMEOUT) m_act_cnt = m_act_cnt + 1;
      if (m_hard) m_vsd_sel = 1'b0;
      else if (sd_img_mounted) m_vsd_sel = (img_size != 64'd0);
      m_old_mosi = spi_mosi;
      m_old_miso = miso_now;
      m_hard     = hard_terms;
      m_core     = core_terms;
      m_menu     = 16'd0;
      m_menu[1]  = rom_a_hide || ocm_mode;
      m_menu[2]  = rom_b_hide || ocm_mode;
      m_menu[3]  = ocm_mode;
      m_menu[9:4] = fdd_present;
      m_menu[10] = !sram_present;
      m_menu[11] = status[glue_host_pkg::ST_TAPE_ADC];
      // Video options
      scale   = status[5:3];
      aspect  = status[2:1];
      sd_next = forced_scandoubler || (scale != 3'd0);
      sl_full = scale - 3'd1;
      if (rst) begin
         m_vga_sl = 2'd0;
         m_hq2x   = 1'b0;
         m_sd     = 1'b0;
         m_arx    = 12'd4;
         m_ary    = 12'd3;
         m_crop   = 12'd0;
      end else begin
         m_vga_sl = (scale == 3'd0) ? 2'd0 : sl_full[1:0];
         m_hq2x   = (scale == 3'd1);
         m_sd     = sd_next;
         m_arx    = (aspect == 2'd0) ? 12'd4 : 12'(aspect) - 12'd1;
         m_ary    = (aspect == 2'd0) ? 12'd3 : 12'd0;
         m_crop   = (hdmi_width == 12'd1920 && hdmi_height == 12'd1080 && !sd_next)
                  ? 12'd216 : 12'd0;
      end
   endtask

   //====================
   // Checks
   //====================
   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] time %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_outputs();
      logic act;
      act = (m_act_cnt < ACT_TIMEOUT);
      check_value("hard_reset", 64'(hard_reset), 64'(m_hard));
      check_value("core_reset", 64'(core_reset), 64'(m_core));
      check_value("play", 64'(play), 64'(!motor && m_cas_load));
      check_value("rewind", 64'(rewind), 64'(m_rewind));
      check_value("menu_mask", 64'(menu_mask), 64'(m_menu));
      check_value("sd_cs", 64'(sd_cs), 64'(m_vsd_sel));
      check_value("sd_sck", 64'(sd_sck), 64'(spi_sck && !m_vsd_sel));
      check_value("sd_mosi", 64'(sd_mosi), 64'(spi_mosi && !m_vsd_sel));
      check_value("miso_to_core", 64'(miso_to_core), 64'(m_vsd_sel ? vsd_miso : sd_miso));
      check_value("led_user", 64'(led_user), 64'(m_vsd_sel && act));
      check_value("led_disk", 64'(led_disk), 64'({1'b1, !m_vsd_sel && act}));
      check_value("ch_addr", 64'(ch_addr), 64'(upload ? up_addr : mx_addr));
      check_value("ch_din", 64'(ch_din), 64'(upload ? up_data : mx_data));
      check_value("ch_rnw", 64'(ch_rnw), 64'(upload ? up_rnw : mx_rnw));
      check_value("ch_req", 64'(ch_req), 64'(upload ? up_cs : mx_cs));
      check_value("up_q", 64'(up_q), 64'(up_cs ? sdram_dout : 8'hff));
      check_value("mx_q", 64'(mx_q), 64'(mx_cs ? sdram_dout : 8'hff));
      check_value("up_ready", 64'(up_ready), 64'(sdram_ready));
      check_value("mx_ready", 64'(mx_ready), 64'(sdram_ready));
      check_value("vga_sl", 64'(vga_sl), 64'(m_vga_sl));
      check_value("hq2x", 64'(hq2x), 64'(m_hq2x));
      check_value("scandoubler", 64'(scandoubler), 64'(m_sd));
      check_value("arx", 64'(arx), 64'(m_arx));
      check_value("ary", 64'(ary), 64'(m_ary));
      check_value("crop_size", 64'(crop_size), 64'(m_crop));
   endtask

   //====================
   // Main sequence
   //====================
   initial begin
      rng = 32'd29;
      opt_bits = 64'd0;
      status = '0;
      {upload_reset, sd_img_mounted, fdc_enable, ioctl_download, motor} = 5'd0;
      ioctl_index = 16'd0;
      {rom_a_hide, rom_b_hide, ocm_mode, sram_present} = 4'd0;
      fdd_present = 6'd0;
      img_size = 64'd0;
      {spi_sck, spi_mosi, sd_miso, vsd_miso} = 4'd0;
      {upload, up_rnw, up_cs, mx_rnw, mx_cs, sdram_ready} = 6'd0;
      up_addr = 27'd0;
      mx_addr = 27'd0;
      {up_data, mx_data, sdram_dout} = 24'd0;
      forced_scandoubler = 1'b0;
      hdmi_width  = 12'd1920;
      hdmi_height = 12'd1080;
      cas_left   = 0;
      burst_left = 0;
      {m_hard, m_core, m_rewind, m_is_cas_d, m_cas_load} = 5'b11000;
      {m_vsd_sel, m_old_mosi, m_old_miso} = 3'd0;
      m_act_cnt = ACT_TIMEOUT;
      m_menu = 16'd0;
      for (int i = 0; i < NUM_CYCLES; i++) begin
         @(negedge clock_bus);
         drive_inputs();
         #1;
         step_model();
         @(posedge clock_bus);
         #1;
         if (i >= CHECK_START) check_outputs();
      end
      $display("Result: PASSED");
      $finish;
   end

   // Hang guard
   always @(posedge clock_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
         $display("Result: FAILED");
         $fatal(1, "Timeout");
      end
   end

endmodule

// ==== vlog.f ====
source/glue_host_pkg.sv
source/glue_video_pkg.sv
source/glue_control.sv
source/sd_route.sv
source/sdram_port_mux.sv
source/video_option_decode.sv
source/msx_glue_top.sv
tb/tb_clock_gen.sv
tb/tb_msx_glue.sv
